/* dv/camera_spi_tests.svh */
task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
  if (got !== exp) begin
    $display("ERROR %0t %s got %02h expected %02h", $time, name, got, exp);
    error_count++;
  end
endtask

task automatic compare_count(input string name, input int got, input int exp);
  if (got !== exp) begin
    $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    error_count++;
  end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    error_count++;
  end
endtask

task automatic log_result(input string name, input int errs_before);
  if (error_count == errs_before) begin
    tests_passed++;
    $display("test %s passed", name);
  end else begin
    tests_failed++;
    $display("test %s failed with %0d errors", name, error_count - errs_before);
  end
endtask

// pixel k of each packet is checked on copi line k
task automatic match_packets(input bit allow_drops);
  int idx;
  idx = 0;
  if (!allow_drops) compare_count("received packets", rx_q.size(), exp_q.size());
  foreach (rx_q[p]) begin
    while (allow_drops && idx < exp_q.size() && exp_q[idx] != rx_q[p]) idx++;   // skip dropped
    if (idx >= exp_q.size()) begin
      $display("received packet %0d matches no remaining expected packet", p);
      error_count++;
      break;
    end
    for (int k = 0; k < SPI_LINES; k++) begin
      compare_pixel($sformatf("copi[%0d] packet %0d", k, p), rx_q[p][k], exp_q[idx][k]);
    end
    idx++;
  end
endtask

task automatic reset_quiet();
  int errs;
  errs = error_count;
  repeat (64) @(posedge clk_camera);   // no camera activity at all
  compare_flag("cs", cs, 1'b1);
  compare_flag("dclk", dclk, 1'b0);
  compare_flag("overflow", overflow, 1'b0);
  for (int i = 0; i < SPI_LINES; i++) begin
    compare_flag($sformatf("copi[%0d]", i), copi[i], 1'b0);   // each line idles at zero
  end
  compare_count("received packets", rx_q.size(), 0);
  log_result("reset state", errs);
endtask

task automatic slow_frame_order();
  int errs;
  errs = error_count;
  exp_q.delete();
  rx_q.delete();
  drive_frame(VRES, HRES, 2, 2 + SLOW_IDLE, 1'b0, 1'b0, 1'b1);
  wait_idle();
  match_packets(1'b0);
  compare_flag("overflow", overflow, 1'b0);
  log_result("slow frame", errs);
endtask

task automatic pclk_glitch_filter();
  int errs;
  errs = error_count;
  exp_q.delete();
  rx_q.delete();
  drive_frame(VRES, HRES, 6, 2, 1'b0, 1'b1, 1'b1);   // long pclk high, stray pixels
  wait_idle();
  match_packets(1'b0);
  log_result("pclk held high and hsync low pixels", errs);
endtask

task automatic vsync_drops_partial();
  int errs;
  errs = error_count;
  exp_q.delete();
  rx_q.delete();
  drive_frame(1, 6, 2, 2 + SLOW_IDLE, 1'b0, 1'b0, 1'b0);   // 3 kept pixels, half a packet
  drive_frame(VRES, HRES, 2, 2 + SLOW_IDLE, 1'b0, 1'b0, 1'b1);
  wait_idle();
  match_packets(1'b0);
  log_result("vsync mid packet", errs);
endtask

task automatic fast_frame_overflow();
  int errs;
  int frames;
  errs   = error_count;
  frames = 0;
  exp_q.delete();
  rx_q.delete();
  // 2 clocks per pixel, odd rows blank, back to back until credits run out
  while (frames < FAST_FRAMES && !overflow) begin
    drive_frame(VRES, HRES, 1, 1, 1'b1, 1'b0, 1'b1);
    frames++;
  end
  wait_idle();
  compare_flag("overflow", overflow, 1'b1);
  compare_flag("queue depth reached", rx_q.size() >= SPI_QUEUE_DEPTH, 1'b1);
  match_packets(1'b1);
  log_result($sformatf("fast frames (%0d sent)", frames), errs);
endtask

/* dv/camera_spi_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module camera_spi_tb;
  import camera_spi_pkg::*;

  localparam int HRES            = 16;
  localparam int VRES            = 8;
  localparam int DATA_CLK_PERIOD = 4;
  localparam int RNG_SEED        = 69625;
  localparam int SLOW_IDLE       = 4;    // extra clocks after each slow pixel
  localparam int FAST_FRAMES     = 12;   // upper bound while waiting for overflow
  localparam int IDLE_CLKS       = 16;   // cs high this long, sender is drained
  localparam int FRAMES          = 4 + FAST_FRAMES;
  localparam int PACKETS         = FRAMES * (HRES / 2) * (VRES / 2) / SPI_LINES;
  // worst pixel takes 8 clocks, a line adds up to 16 for hsync and a stray pixel
  localparam int FRAME_CLKS      = HRES * VRES * 8 + VRES * 16;
  localparam int PACKET_CLKS     = 8 * DATA_CLK_PERIOD + 4;
  localparam int TIMEOUT_CYCLES  = 2 * (FRAMES * FRAME_CLKS + PACKETS * PACKET_CLKS);

  logic                 clk_camera = 1'b0;
  logic                 sys_rst_camera;
  pixel_t               camera_d;
  logic                 cam_pclk;
  logic                 cam_hsync;
  logic                 cam_vsync;
  logic [SPI_LINES-1:0] copi;
  logic                 dclk;
  logic                 cs;
  logic                 overflow;

  packet_t     exp_q[$];        // expected packets in raster order
  packet_t     rx_q[$];         // packets rebuilt from copi
  packet_t     rx_shift;
  int          rx_bits;
  logic        dclk_q;
  int          cycle_count  = 0;
  int          error_count  = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int unsigned rnd;

  always #2 clk_camera = ~clk_camera;   // 4 ns

  camera_spi_top #(
    .HRES            (HRES),
    .VRES            (VRES),
    .DATA_CLK_PERIOD (DATA_CLK_PERIOD)
  ) camera_spi_top_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .camera_d       (camera_d),
    .cam_pclk       (cam_pclk),
    .cam_hsync      (cam_hsync),
    .cam_vsync      (cam_vsync),
    .copi           (copi),
    .dclk           (dclk),
    .cs             (cs),
    .overflow       (overflow)
  );

  // one camera pixel, data changes with the pclk rise
  task automatic pulse_pixel(input pixel_t value, input int high_clks, input int low_clks);
    camera_d <= value;
    cam_pclk <= 1'b1;
    repeat (high_clks) @(posedge clk_camera);
    cam_pclk <= 1'b0;
    repeat (low_clks) @(posedge clk_camera);
  endtask

  // vsync pulse then rows of pixels, odd rows may be left blank
  task automatic drive_frame(input int rows, input int cols, input int high_clks,
                             input int low_clks, input bit blank_odd, input bit stray,
                             input bit record);
    pixel_t  kept[$];
    pixel_t  value;
    packet_t pkt;
    cam_vsync <= 1'b1;
    repeat (2) @(posedge clk_camera);
    cam_vsync <= 1'b0;
    repeat (2) @(posedge clk_camera);
    for (int r = 0; r < rows; r++) begin
      cam_hsync <= 1'b1;
      @(posedge clk_camera);
      for (int c = 0; c < cols && !(blank_odd && (r % 2 == 1)); c++) begin
        value = pixel_t'($urandom);
        pulse_pixel(value, high_clks, low_clks);
        if ((r % 2 == 0) && (c % 2 == 0)) kept.push_back(value);   // 2x downsample
      end
      cam_hsync <= 1'b0;
      @(posedge clk_camera);
      if (stray) pulse_pixel(pixel_t'($urandom), 2, 2);   // hsync low, not a pixel
    end
    // six kept pixels per packet, a short tail never leaves the packer
    while (record && kept.size() >= SPI_LINES) begin
      for (int k = 0; k < SPI_LINES; k++) pkt[k] = kept.pop_front();
      exp_q.push_back(pkt);
    end
  endtask

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < IDLE_CLKS) begin
      @(posedge clk_camera);
      quiet = cs ? quiet + 1 : 0;
    end
  endtask

  // sample copi on each dclk rise while cs is low
  always @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      rx_bits = 0;
      dclk_q  = 1'b0;
    end else begin
      if (!cs && dclk && !dclk_q) begin
        for (int i = 0; i < SPI_LINES; i++) begin
          rx_shift[i] = {rx_shift[i][6:0], copi[i]};   // msb arrives first
        end
        rx_bits++;
      end
      if (rx_bits == 8) begin
        rx_q.push_back(rx_shift);
        rx_bits = 0;
      end else if (cs && rx_bits != 0) begin
        $display("transfer at %0t ended after %0d of 8 bits", $time, rx_bits);
        error_count++;
        rx_bits = 0;
      end
      dclk_q = dclk;
    end
  end

  always @(posedge clk_camera) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout, run still busy after %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  `include "camera_spi_tests.svh"

  initial begin
    rnd            = $urandom(RNG_SEED);
    sys_rst_camera = 1'b1;
    camera_d       = '0;
    cam_pclk       = 1'b0;
    cam_hsync      = 1'b0;
    cam_vsync      = 1'b0;
    repeat (2) @(posedge clk_camera);
    sys_rst_camera <= 1'b0;
    @(posedge clk_camera);
    reset_quiet();
    slow_frame_order();
    pclk_glitch_filter();
    vsync_drops_partial();
    fast_frame_overflow();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+dv
verilog/camera_spi_pkg.sv
verilog/camera_input_sync.sv
verilog/pixel_reconstruct.sv
verilog/downsample_packer.sv
verilog/spi_send_con.sv
verilog/camera_spi_top.sv
dv/camera_spi_tb.sv

/* verilog/camera_input_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module camera_input_sync (
  input  wire                          clk_camera,
  input  wire                          sys_rst_camera,
  input  wire camera_spi_pkg::pixel_t  camera_d,
  input  wire                          cam_pclk,
  input  wire                          cam_hsync,
  input  wire                          cam_vsync,
  output camera_spi_pkg::pixel_t       sync_d,
  output logic                         sync_pclk,
  output logic                         sync_hsync,
  output logic                         sync_vsync
);
  import camera_spi_pkg::*;

  // first stage, may go metastable
  pixel_t d_meta;
  logic   pclk_meta;
  logic   hsync_meta;
  logic   vsync_meta;

  // pins are asynchronous to clk_camera, two flops each
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      d_meta     <= '0;
      pclk_meta  <= 1'b0;
      hsync_meta <= 1'b0;
      vsync_meta <= 1'b0;
      sync_d     <= '0;
      sync_pclk  <= 1'b0;   // low so a held-high pclk shows as one clean rise
      sync_hsync <= 1'b0;
      sync_vsync <= 1'b0;
    end else begin
      d_meta     <= camera_d;
      pclk_meta  <= cam_pclk;
      hsync_meta <= cam_hsync;
      vsync_meta <= cam_vsync;
      sync_d     <= d_meta;     // 2 cycles after the pin
      sync_pclk  <= pclk_meta;
      sync_hsync <= hsync_meta;
      sync_vsync <= vsync_meta;
    end
  end

endmodule

`default_nettype wire

/* verilog/camera_spi_pkg.sv */
`default_nettype none

package camera_spi_pkg;

  // one luminance byte per camera pixel clock
  localparam int PIXEL_W = 8;

  // wide enough for 1280x720 coordinates
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // data lines on the spi side, also pixels per packet
  localparam int SPI_LINES = 6;

  // entries in the sender queue
  // the packer starts with this many credits
  localparam int SPI_QUEUE_DEPTH = 2;

  typedef logic [PIXEL_W-1:0] pixel_t;   // 8-bit luminance sample

  typedef logic [HCOUNT_W-1:0] hcount_t; // column within a line
  typedef logic [VCOUNT_W-1:0] vcount_t; // line within a frame

  // six pixels, pixel 0 sits in the low byte
  // index i also selects spi data line i
  typedef logic [SPI_LINES-1:0][PIXEL_W-1:0] packet_t;

  typedef logic [1:0] credit_t;          // 0..SPI_QUEUE_DEPTH

  // sender fsm
  typedef enum logic [1:0] {
    SPI_IDLE,   // cs high, waiting for a queued packet
    SPI_LOAD,   // head of queue moves into the shifters
    SPI_SHIFT   // cs low, eight dclk periods
  } spi_state_t;

endpackage

`default_nettype wire

/* verilog/camera_spi_top.sv */
`timescale 1ns/100ps
`default_nettype none

module camera_spi_top #(
  parameter int HRES            = 1280,
  parameter int VRES            = 720,
  parameter int DATA_CLK_PERIOD = 6     // clk_camera cycles per dclk
) (
  input  wire                                  clk_camera,
  input  wire                                  sys_rst_camera,
  input  wire camera_spi_pkg::pixel_t          camera_d,
  input  wire                                  cam_pclk,
  input  wire                                  cam_hsync,
  input  wire                                  cam_vsync,
  output logic [camera_spi_pkg::SPI_LINES-1:0] copi,
  output logic                                 dclk,
  output logic                                 cs,
  output logic                                 overflow
);
  import camera_spi_pkg::*;

  // synchronized camera pins
  pixel_t  sync_d;
  logic    sync_pclk;
  logic    sync_hsync;
  logic    sync_vsync;

  // reconstructed pixel stream
  logic    pixel_valid;
  pixel_t  pixel_data;
  hcount_t hcount;
  vcount_t vcount;
  logic    frame_start;

  // packer to sender, credit based
  logic    packet_push;
  packet_t packet_data;
  logic    credit_return;

  camera_input_sync camera_input_sync_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .camera_d       (camera_d),
    .cam_pclk       (cam_pclk),
    .cam_hsync      (cam_hsync),
    .cam_vsync      (cam_vsync),
    .sync_d         (sync_d),
    .sync_pclk      (sync_pclk),
    .sync_hsync     (sync_hsync),
    .sync_vsync     (sync_vsync)
  );

  pixel_reconstruct #(
    .HRES (HRES),
    .VRES (VRES)
  ) pixel_reconstruct_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .sync_d         (sync_d),
    .sync_pclk      (sync_pclk),
    .sync_hsync     (sync_hsync),
    .sync_vsync     (sync_vsync),
    .pixel_valid    (pixel_valid),
    .pixel_data     (pixel_data),
    .hcount         (hcount),
    .vcount         (vcount),
    .frame_start    (frame_start)
  );

  downsample_packer downsample_packer_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pixel_valid    (pixel_valid),
    .pixel_data     (pixel_data),
    .hcount         (hcount),
    .vcount         (vcount),
    .frame_start    (frame_start),
    .credit_return  (credit_return),
    .packet_push    (packet_push),
    .packet_data    (packet_data),
    .overflow       (overflow)
  );

  spi_send_con #(
    .DATA_CLK_PERIOD (DATA_CLK_PERIOD)
  ) spi_send_con_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .packet_push    (packet_push),
    .packet_data    (packet_data),
    .credit_return  (credit_return),
    .copi           (copi),
    .dclk           (dclk),
    .cs             (cs)
  );

endmodule

`default_nettype wire

/* verilog/downsample_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module downsample_packer (
  input  wire                           clk_camera,
  input  wire                           sys_rst_camera,
  input  wire                           pixel_valid,
  input  wire camera_spi_pkg::pixel_t   pixel_data,
  input  wire camera_spi_pkg::hcount_t  hcount,
  input  wire camera_spi_pkg::vcount_t  vcount,
  input  wire                           frame_start,
  input  wire                           credit_return,
  output logic                          packet_push,
  output camera_spi_pkg::packet_t       packet_data,
  output logic                          overflow
);
  import camera_spi_pkg::*;

  localparam int FILL_W = $clog2(SPI_LINES);

  logic              keep;         // even row and even column
  logic              pack_done;    // sixth kept pixel this cycle
  logic              spend;        // packet goes to the sender
  logic [FILL_W-1:0] fill;         // kept pixels already in packet_reg
  packet_t           packet_reg;
  packet_t           packet_next;
  credit_t           credits;      // free sender queue entries

  // 2x downsample in both dimensions
  // a pixel arriving with frame_start belongs to no packet
  assign keep = pixel_valid && !hcount[0] && !vcount[0] && !frame_start;

  // new pixel enters at the top so the first kept pixel ends up in byte 0
  assign packet_next = {pixel_data, packet_reg[SPI_LINES-1:1]};

  assign pack_done = keep && (fill == FILL_W'(SPI_LINES - 1));
  assign spend     = pack_done && (credits != '0);

  always_ff @(posedge clk_camera) begin
    if (keep) begin
      packet_reg <= packet_next;
    end
    if (pack_done) begin
      packet_data <= packet_next;   // held until the next full packet
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      fill        <= '0;
      packet_push <= 1'b0;
      overflow    <= 1'b0;
      credits     <= credit_t'(SPI_QUEUE_DEPTH);
    end else begin
      packet_push <= spend;         // 1 cycle after the sixth kept pixel

      if (pack_done && (credits == '0)) begin
        overflow <= 1'b1;           // whole packet dropped, sticky until reset
      end

      if (frame_start) begin
        fill <= '0;                 // partial packet is thrown away
      end else if (keep) begin
        fill <= pack_done ? '0 : fill + 1'b1;
      end

      case ({spend, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;    // none, or spend and return together
      endcase
    end
  end

  // sender returns exactly one credit per packet it took
  a_credit_bound : assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
    credits <= credit_t'(SPI_QUEUE_DEPTH)
  ) else $error("credit count %0d above queue depth", credits);

endmodule

`default_nettype wire

/* verilog/pixel_reconstruct.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_reconstruct #(
  parameter int HRES = 1280,
  parameter int VRES = 720
) (
  input  wire                          clk_camera,
  input  wire                          sys_rst_camera,
  input  wire camera_spi_pkg::pixel_t  sync_d,
  input  wire                          sync_pclk,
  input  wire                          sync_hsync,
  input  wire                          sync_vsync,
  output logic                         pixel_valid,
  output camera_spi_pkg::pixel_t       pixel_data,
  output camera_spi_pkg::hcount_t      hcount,
  output camera_spi_pkg::vcount_t      vcount,
  output logic                         frame_start
);
  import camera_spi_pkg::*;

  // previous samples for edge detect
  logic pclk_prev;
  logic hsync_prev;
  logic vsync_prev;

  logic pclk_rise;
  logic hsync_fall;
  logic vsync_rise;
  logic capture;

  // position of the next pixel to be captured
  hcount_t h_ptr;
  vcount_t v_ptr;

  assign pclk_rise  = sync_pclk & ~pclk_prev;
  assign hsync_fall = ~sync_hsync & hsync_prev;   // end of a line
  assign vsync_rise = sync_vsync & ~vsync_prev;   // start of a frame
  assign capture    = pclk_rise & sync_hsync;     // one byte per rise, active line only

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pclk_prev   <= 1'b0;
      hsync_prev  <= 1'b0;
      vsync_prev  <= 1'b0;
      pixel_valid <= 1'b0;
      frame_start <= 1'b0;
      h_ptr       <= '0;
      v_ptr       <= '0;
    end else begin
      pclk_prev   <= sync_pclk;
      hsync_prev  <= sync_hsync;
      vsync_prev  <= sync_vsync;
      pixel_valid <= capture;      // 1 cycle after the rise is seen
      frame_start <= vsync_rise;

      if (vsync_rise) begin
        // new frame restarts both counters
        h_ptr <= '0;
        v_ptr <= '0;
      end else if (hsync_fall) begin
        h_ptr <= '0;
        v_ptr <= v_ptr + 1'b1;
      end else if (capture) begin
        h_ptr <= h_ptr + 1'b1;
      end
    end
  end

  // coordinates travel with the byte, qualified by pixel_valid
  always_ff @(posedge clk_camera) begin
    if (capture) begin
      pixel_data <= sync_d;
      hcount     <= h_ptr;
      vcount     <= v_ptr;
    end
  end

  // a camera with the wrong mode would run the counters past the frame
  a_coord_in_frame : assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
    pixel_valid |-> ((hcount < HRES) && (vcount < VRES))
  ) else $error("pixel coordinate outside %0dx%0d frame", HRES, VRES);

endmodule

`default_nettype wire

/* verilog/spi_send_con.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_send_con #(
  parameter int DATA_CLK_PERIOD = 6
) (
  input  wire                                  clk_camera,
  input  wire                                  sys_rst_camera,
  input  wire                                  packet_push,
  input  wire camera_spi_pkg::packet_t         packet_data,
  output logic                                 credit_return,
  output logic [camera_spi_pkg::SPI_LINES-1:0] copi,
  output logic                                 dclk,
  output logic                                 cs
);
  import camera_spi_pkg::*;

  localparam int HALF  = DATA_CLK_PERIOD / 2;
  localparam int PH_W  = $clog2(DATA_CLK_PERIOD);
  localparam int PTR_W = (SPI_QUEUE_DEPTH > 1) ? $clog2(SPI_QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(SPI_QUEUE_DEPTH + 1);
  localparam int BIT_W = $clog2(PIXEL_W);

  // packet queue
  packet_t          queue_mem [SPI_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  logic             q_full;
  logic             q_pop;

  // shifter
  spi_state_t       state;
  logic [PH_W-1:0]  phase;        // position inside one dclk period
  logic [BIT_W-1:0] bit_cnt;
  logic             period_end;
  logic             last_bit;
  packet_t          shreg;        // one byte per data line

  assign q_full     = (q_count == CNT_W'(SPI_QUEUE_DEPTH));
  assign q_pop      = (state == SPI_LOAD);           // head leaves in the load cycle
  assign period_end = (phase == PH_W'(DATA_CLK_PERIOD - 1));
  assign last_bit   = (bit_cnt == BIT_W'(PIXEL_W - 1));

  assign credit_return = q_pop;   // one pulse per packet taken

  always_ff @(posedge clk_camera) begin
    if (packet_push) begin
      queue_mem[wr_ptr] <= packet_data;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (packet_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(SPI_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(SPI_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({packet_push, q_pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      state   <= SPI_IDLE;
      phase   <= '0;
      bit_cnt <= '0;
      shreg   <= '0;     // copi reads zero out of reset
      dclk    <= 1'b0;
      cs      <= 1'b1;
    end else begin
      case (state)
        SPI_IDLE: begin
          // a push this cycle is written in time for the load
          if ((q_count != '0) || packet_push) begin
            state <= SPI_LOAD;
          end
        end
        SPI_LOAD: begin
          shreg   <= queue_mem[rd_ptr];
          phase   <= '0;
          bit_cnt <= '0;
          dclk    <= 1'b0;
          cs      <= 1'b0;     // falls 2 cycles after the push
          state   <= SPI_SHIFT;
        end
        SPI_SHIFT: begin
          // low for the first half period, high for the second
          dclk <= (phase >= PH_W'(HALF - 1)) && !period_end;
          if (period_end) begin
            phase   <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            for (int i = 0; i < SPI_LINES; i++) begin
              shreg[i] <= {shreg[i][PIXEL_W-2:0], 1'b0};   // next bit while dclk falls
            end
            if (last_bit) begin
              cs    <= 1'b1;   // 8 periods done
              state <= SPI_IDLE;
            end
          end else begin
            phase <= phase + 1'b1;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // msb first, line i carries pixel i
  always_comb begin
    for (int i = 0; i < SPI_LINES; i++) begin
      copi[i] = shreg[i][PIXEL_W-1];
    end
  end

  // the packer credit counter must keep pushes away from a full queue
  a_no_push_when_full : assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
    packet_push |-> !q_full
  ) else $error("packet pushed into a full spi queue");

endmodule

`default_nettype wire
